// File: compile.f
hdl/rv_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/exec_stage.sv
hdl/rv_core.sv
verification/tb_clock.sv
verification/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/decoder.sv
  - hdl/regfile.sv
  - hdl/alu.sv
  - hdl/exec_stage.sv
  - hdl/rv_core.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/tb_rv_core.sv

// File: verification/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam int TABLE_LEN      = 27;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TABLE_LEN + 2 + 10;

    logic      clk;
    logic      arst_n;
    logic      instr_valid;
    instr_t    instr;
    logic      commit_valid;
    logic      commit_illegal;
    reg_addr_t commit_rd;
    xlen_t     commit_data;

    instr_t    t_instr [TABLE_LEN];
    logic      t_valid [TABLE_LEN];
    reg_addr_t t_rd    [TABLE_LEN];
    logic      t_ill   [TABLE_LEN];
    xlen_t     t_data  [TABLE_LEN];

    int n_entries    = 0;
    int error_count  = 0;
    int commit_count = 0;
    int cycle_count  = 0;
    int exp_q [$];

    tb_clock u_clock (
        .clk (clk)
    );

    rv_core UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .commit_valid   (commit_valid),
        .commit_illegal (commit_illegal),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data)
    );

    function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm12, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd,
                                      input logic [6:0] opc);
        return {imm12, rs1, f3, rd, opc};
    endfunction

    task automatic add_op(input instr_t word, input reg_addr_t rd, input logic ill,
                          input xlen_t data);
        t_instr[n_entries] = word;
        t_valid[n_entries] = 1'b1;
        t_rd[n_entries]    = rd;
        t_ill[n_entries]   = ill;
        t_data[n_entries]  = data;
        n_entries++;
    endtask

    task automatic add_idle();
        t_instr[n_entries] = '0;
        t_valid[n_entries] = 1'b0;
        t_rd[n_entries]    = '0;
        t_ill[n_entries]   = 1'b0;
        t_data[n_entries]  = '0;
        n_entries++;
    endtask

    task automatic build_table();
        // Immediate forms
        add_op(i_type(12'h123, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM), 5'd1, 1'b0, 64'h123);
        add_op(i_type(12'hFFF, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM), 5'd2, 1'b0, '1);
        add_idle();
        add_op(i_type(12'h0F0, 5'd1, F3_XOR, 5'd3, OPC_OP_IMM), 5'd3, 1'b0, 64'h1D3);
        add_op(i_type(12'h800, 5'd1, F3_OR, 5'd4, OPC_OP_IMM), 5'd4, 1'b0,
               64'hFFFF_FFFF_FFFF_F923);
        // x4 forwarded on ra1
        add_op(i_type(12'hFF0, 5'd4, F3_AND, 5'd6, OPC_OP_IMM), 5'd6, 1'b0,
               64'hFFFF_FFFF_FFFF_F920);
        add_op(i_type(12'h7AB, 5'd2, F3_AND, 5'd5, OPC_OP_IMM), 5'd5, 1'b0, 64'h7AB);
        // Register forms, forwarding on ra2 then ra1
        add_op(r_type(F7_BASE, 5'd5, 5'd3, F3_ADD_SUB, 5'd7, OPC_OP), 5'd7, 1'b0, 64'h97E);
        add_op(r_type(F7_ALT, 5'd7, 5'd1, F3_ADD_SUB, 5'd8, OPC_OP), 5'd8, 1'b0,
               64'hFFFF_FFFF_FFFF_F7A5);
        add_op(r_type(F7_BASE, 5'd2, 5'd8, F3_XOR, 5'd9, OPC_OP), 5'd9, 1'b0, 64'h85A);
        add_op(r_type(F7_BASE, 5'd9, 5'd5, F3_OR, 5'd10, OPC_OP), 5'd10, 1'b0, 64'hFFB);
        add_op(r_type(F7_BASE, 5'd6, 5'd10, F3_AND, 5'd11, OPC_OP), 5'd11, 1'b0, 64'h920);
        add_idle();
        // Direct register file read after the idle slot
        add_op(r_type(F7_BASE, 5'd11, 5'd11, F3_ADD_SUB, 5'd12, OPC_OP), 5'd12, 1'b0,
               64'h1240);
        // Word forms
        add_op(r_type(F7_BASE, 5'd4, 5'd1, F3_ADD_SUB, 5'd13, OPC_OP_32), 5'd13, 1'b0,
               64'hFFFF_FFFF_FFFF_FA46);
        add_op(r_type(F7_ALT, 5'd7, 5'd5, F3_ADD_SUB, 5'd14, OPC_OP_32), 5'd14, 1'b0,
               64'hFFFF_FFFF_FFFF_FE2D);
        add_op(i_type(12'h7FF, 5'd14, F3_ADD_SUB, 5'd15, OPC_OP_IMM_32), 5'd15, 1'b0,
               64'h62C);
        add_op(i_type(12'h800, 5'd2, F3_ADD_SUB, 5'd16, OPC_OP_IMM_32), 5'd16, 1'b0,
               64'hFFFF_FFFF_FFFF_F7FF);
        // Illegal: SYSTEM opcode, XOR in word group, ADD with funct7 of 1
        add_op(32'h0000_00F3, 5'd0, 1'b1, '0);
        add_op(r_type(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd3, OPC_OP_32), 5'd0, 1'b1, '0);
        add_op(r_type(7'h01, 5'd2, 5'd1, F3_ADD_SUB, 5'd5, OPC_OP), 5'd0, 1'b1, '0);
        // x1, x3 and x5 keep their old values
        add_op(r_type(F7_BASE, 5'd3, 5'd1, F3_ADD_SUB, 5'd17, OPC_OP), 5'd17, 1'b0, 64'h2F6);
        add_op(i_type(12'h000, 5'd5, F3_ADD_SUB, 5'd18, OPC_OP_IMM), 5'd18, 1'b0, 64'h7AB);
        // Write to x0 shows its result, x0 still reads zero
        add_op(i_type(12'h055, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP_IMM), 5'd0, 1'b0, 64'h178);
        add_op(r_type(F7_BASE, 5'd12, 5'd0, F3_ADD_SUB, 5'd19, OPC_OP), 5'd19, 1'b0,
               64'h1240);
        add_idle();
        add_op(r_type(F7_ALT, 5'd0, 5'd19, F3_ADD_SUB, 5'd20, OPC_OP), 5'd20, 1'b0,
               64'h1240);
    endtask

    initial begin
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < n_entries; i++) begin
            @(posedge clk);
            instr_valid <= t_valid[i];
            instr       <= t_instr[i];
            if (t_valid[i]) begin
                exp_q.push_back(i);
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // Watch for stray commits after the last one
        repeat (3) @(posedge clk);

        $display("Commits checked: %0d, errors: %0d", commit_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Outputs are registered, so sample mid-cycle
    always @(negedge clk) begin : check_commits
        int idx;
        if (arst_n && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected commit at time %0t with no instruction pending", $time);
                error_count++;
            end else begin
                idx = exp_q.pop_front();
                commit_count++;
                if (commit_rd !== t_rd[idx]) begin
                    $display("FAIL t=%0t commit_rd expected %0d got %0d",
                             $time, t_rd[idx], commit_rd);
                    error_count++;
                end
                if (commit_illegal !== t_ill[idx]) begin
                    $display("FAIL t=%0t commit_illegal expected %b got %b",
                             $time, t_ill[idx], commit_illegal);
                    error_count++;
                end
                if (commit_data !== t_data[idx]) begin
                    $display("FAIL t=%0t commit_data expected %h got %h",
                             $time, t_data[idx], commit_data);
                    error_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d expected commits never seen",
                     cycle_count, exp_q.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 50ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      commit_valid,
    output logic      commit_illegal,
    output reg_addr_t commit_rd,
    output xlen_t     commit_data
);

    reg_addr_t ra1;
    reg_addr_t ra2;
    reg_addr_t wa;
    xlen_t     imm;
    alu_func_t alu_func;
    logic      use_imm;
    logic      word_op;
    logic      reg_write;
    logic      illegal;
    xlen_t     rdata1;
    xlen_t     rdata2;
    logic      we;
    reg_addr_t waddr;
    xlen_t     wdata;

    decoder u_decoder (
        .instr     (instr),
        .ra1       (ra1),
        .ra2       (ra2),
        .wa        (wa),
        .imm       (imm),
        .alu_func  (alu_func),
        .use_imm   (use_imm),
        .word_op   (word_op),
        .reg_write (reg_write),
        .illegal   (illegal)
    );

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (ra1),
        .ra2    (ra2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    exec_stage u_exec_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_valid    (instr_valid),
        .ra1            (ra1),
        .ra2            (ra2),
        .wa             (wa),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .imm            (imm),
        .alu_func       (alu_func),
        .use_imm        (use_imm),
        .word_op        (word_op),
        .reg_write      (reg_write),
        .illegal        (illegal),
        .we             (we),
        .waddr          (waddr),
        .wdata          (wdata),
        .commit_valid   (commit_valid),
        .commit_illegal (commit_illegal),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data)
    );

endmodule

// File: hdl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      instr_valid,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  reg_addr_t wa,
    input  xlen_t     rdata1,
    input  xlen_t     rdata2,
    input  xlen_t     imm,
    input  alu_func_t alu_func,
    input  logic      use_imm,
    input  logic      word_op,
    input  logic      reg_write,
    input  logic      illegal,
    output logic      we,
    output reg_addr_t waddr,
    output xlen_t     wdata,
    output logic      commit_valid,
    output logic      commit_illegal,
    output reg_addr_t commit_rd,
    output xlen_t     commit_data
);

    logic      ex_valid;
    logic      ex_illegal;
    logic      ex_reg_write;
    reg_addr_t ex_wa;
    alu_func_t ex_alu_func;
    logic      ex_word_op;
    xlen_t     ex_a;
    xlen_t     ex_b;
    xlen_t     alu_result;
    logic      fwd_ok;
    xlen_t     src1;
    xlen_t     src2;

    // Bypass from the instruction now in execute
    assign fwd_ok = ex_valid && ex_reg_write && !ex_illegal && ex_wa != '0;
    assign src1   = (fwd_ok && ex_wa == ra1) ? alu_result : rdata1;
    assign src2   = (fwd_ok && ex_wa == ra2) ? alu_result : rdata2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid       <= 1'b0;
            ex_illegal     <= 1'b0;
            ex_reg_write   <= 1'b0;
            commit_valid   <= 1'b0;
            commit_illegal <= 1'b0;
        end else begin
            ex_valid       <= instr_valid;
            ex_illegal     <= illegal;
            ex_reg_write   <= reg_write;
            commit_valid   <= ex_valid;
            commit_illegal <= ex_valid && ex_illegal;
        end
    end

    always_ff @(posedge clk) begin
        ex_wa       <= wa;
        ex_alu_func <= alu_func;
        ex_word_op  <= word_op;
        ex_a        <= src1;
        ex_b        <= use_imm ? imm : src2;
        commit_rd   <= ex_illegal ? '0 : ex_wa;
        commit_data <= ex_illegal ? '0 : alu_result;
    end

    alu u_alu (
        .a        (ex_a),
        .b        (ex_b),
        .alu_func (ex_alu_func),
        .word_op  (ex_word_op),
        .result   (alu_result)
    );

    // Write-back at the end of execute
    assign we    = ex_valid && ex_reg_write && !ex_illegal;
    assign waddr = ex_wa;
    assign wdata = alu_result;

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu
    import rv_pkg::*;
(
    input  xlen_t     a,
    input  xlen_t     b,
    input  alu_func_t alu_func,
    input  logic      word_op,
    output xlen_t     result
);

    xlen_t full;

    always_comb begin
        case (alu_func)
            ALU_ADD: full = a + b;
            ALU_SUB: full = a - b;
            ALU_XOR: full = a ^ b;
            ALU_OR:  full = a | b;
            ALU_AND: full = a & b;
            default: full = '0;
        endcase
    end

    // Low half of a 64-bit add or sub equals the 32-bit result
    assign result = word_op ? {{(XLEN-32){full[31]}}, full[31:0]} : full;

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps

module regfile
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    output xlen_t     rdata1,
    output xlen_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  xlen_t     wdata
);

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    assign rdata1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rdata2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: hdl/decoder.sv
`timescale 1ns/1ps

module decoder
    import rv_pkg::*;
(
    input  instr_t    instr,
    output reg_addr_t ra1,
    output reg_addr_t ra2,
    output reg_addr_t wa,
    output xlen_t     imm,
    output alu_func_t alu_func,
    output logic      use_imm,
    output logic      word_op,
    output logic      reg_write,
    output logic      illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // I-type immediate, sign-extended
    assign imm = {{(XLEN-12){instr[31]}}, instr[31:20]};

    always_comb begin
        ra1       = '0;
        ra2       = '0;
        wa        = '0;
        alu_func  = ALU_ADD;
        use_imm   = 1'b0;
        word_op   = 1'b0;
        reg_write = 1'b0;
        illegal   = 1'b1;

        case (opcode)
            OPC_OP: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        if (funct7 == F7_BASE) begin
                            illegal = 1'b0;
                        end else if (funct7 == F7_ALT) begin
                            alu_func = ALU_SUB;
                            illegal  = 1'b0;
                        end
                    end
                    F3_XOR: begin
                        alu_func = ALU_XOR;
                        illegal  = (funct7 != F7_BASE);
                    end
                    F3_OR: begin
                        alu_func = ALU_OR;
                        illegal  = (funct7 != F7_BASE);
                    end
                    F3_AND: begin
                        alu_func = ALU_AND;
                        illegal  = (funct7 != F7_BASE);
                    end
                    default: ;
                endcase
                if (!illegal) begin
                    ra1 = instr[19:15];
                    ra2 = instr[24:20];
                end
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                illegal = 1'b0;
                case (funct3)
                    F3_ADD_SUB: alu_func = ALU_ADD;
                    F3_XOR:     alu_func = ALU_XOR;
                    F3_OR:      alu_func = ALU_OR;
                    F3_AND:     alu_func = ALU_AND;
                    default:    illegal  = 1'b1;
                endcase
                if (!illegal) begin
                    ra1 = instr[19:15];
                end
            end
            OPC_OP_32: begin
                word_op = 1'b1;
                // Word group only has ADDW and SUBW
                if (funct3 == F3_ADD_SUB) begin
                    if (funct7 == F7_BASE) begin
                        illegal = 1'b0;
                    end else if (funct7 == F7_ALT) begin
                        alu_func = ALU_SUB;
                        illegal  = 1'b0;
                    end
                end
                if (!illegal) begin
                    ra1 = instr[19:15];
                    ra2 = instr[24:20];
                end
            end
            OPC_OP_IMM_32: begin
                word_op = 1'b1;
                use_imm = 1'b1;
                if (funct3 == F3_ADD_SUB) begin
                    illegal = 1'b0;
                    ra1     = instr[19:15];
                end
            end
            default: ;
        endcase

        if (!illegal) begin
            wa        = instr[11:7];
            reg_write = 1'b1;
        end
    end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);
    localparam int ALU_FUNC_W = 3;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ILEN-1:0]       instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ALU_FUNC_W-1:0] alu_func_t;

    // ALU operations
    localparam alu_func_t ALU_ADD = 3'd0;
    localparam alu_func_t ALU_SUB = 3'd1;
    localparam alu_func_t ALU_XOR = 3'd2;
    localparam alu_func_t ALU_OR  = 3'd3;
    localparam alu_func_t ALU_AND = 3'd4;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

    // funct3, instr[14:12]
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, instr[31:25]
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage
